/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= regex_mesh_tb
FILELIST  ?= regex_mesh.f
OBJ_DIR   ?= obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* design/engine_node.sv */
`timescale 1ns/1ns
`default_nettype none

module engine_node #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  regex_mesh_pkg::char_t     cur_char,
    input  logic                      cur_parity,
    input  logic                      enable,
    input  regex_mesh_pkg::pc_token_t x_in_data,
    input  logic                      x_in_valid,
    output logic                      x_in_ready,
    input  regex_mesh_pkg::pc_token_t y_in_data,
    input  logic                      y_in_valid,
    output logic                      y_in_ready,
    output regex_mesh_pkg::pc_token_t x_out_data,
    output logic                      x_out_valid,
    input  logic                      x_out_ready,
    output regex_mesh_pkg::pc_token_t y_out_data,
    output logic                      y_out_valid,
    input  logic                      y_out_ready,
    output logic                      fetch_valid,
    output regex_mesh_pkg::pc_t       fetch_pc,
    input  logic                      fetch_ready,
    input  regex_mesh_pkg::instr_t    fetch_data,
    output logic                      accept,
    output logic                      running,
    output logic                      full
);
    import regex_mesh_pkg::*;

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    engine_state_e    state;
    pc_token_t        cur_tok;
    pc_token_t        out_tok;
    pc_token_t        split_tok;
    logic             out_south;
    instr_t           instr_q;
    opcode_e          opcode;
    pc_t              operand;
    pc_t              next_pc;
    logic             push;
    logic             pop;
    logic             empty;
    pc_token_t        push_data;
    pc_token_t        pop_data;
    logic [1:0]       push_par;
    logic [1:0]       pop_par;
    logic [CNT_W-1:0] par_cnt [2];
    logic             item_live;

    // one input per cycle, north side first
    assign y_in_ready = !full;
    assign x_in_ready = !full && !y_in_valid;
    assign push       = (y_in_valid || x_in_valid) && !full;
    assign push_data  = y_in_valid ? y_in_data : x_in_data;
    assign pop        = (state == IDLE) && enable && !empty;

    pc_fifo #(
        .DEPTH     (FIFO_DEPTH)
    ) fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty),
        .full      (full)
    );

    assign opcode  = instr_opcode(instr_q);
    assign operand = instr_operand(instr_q);
    assign next_pc = cur_tok.pc + 8'd1;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                    if (pop)
                    begin
                        // tokens of the other parity just go round again
                        state <= (pop_data.parity == cur_parity) ? FETCH : EMIT;
                    end
                FETCH:
                    if (fetch_ready)
                    begin
                        state <= EXEC;
                    end
                EXEC:
                    case (opcode)
                        MATCH:   state <= (operand == cur_char) ? EMIT : IDLE;
                        JMP:     state <= EMIT;
                        SPLIT:   state <= EMIT_SPLIT;
                        default: state <= IDLE;
                    endcase
                EMIT:
                    if (out_south ? y_out_ready : x_out_ready)
                    begin
                        state <= IDLE;
                    end
                EMIT_SPLIT:
                    if (x_out_ready)
                    begin
                        state <= EMIT;
                    end
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            cur_tok   <= pop_data;
            out_tok   <= pop_data;
            out_south <= 1'b0;
        end
        if (state == FETCH && fetch_ready)
        begin
            instr_q <= fetch_data;
        end
        if (state == EXEC)
        begin
            case (opcode)
                MATCH:
                begin
                    out_tok.pc     <= next_pc;
                    out_tok.parity <= ~cur_tok.parity;
                    out_south      <= 1'b0;
                end
                JMP:
                begin
                    out_tok.pc     <= operand;
                    out_tok.parity <= cur_tok.parity;
                    out_south      <= 1'b1;
                end
                SPLIT:
                begin
                    out_tok.pc       <= next_pc;
                    out_tok.parity   <= cur_tok.parity;
                    split_tok.pc     <= operand;
                    split_tok.parity <= cur_tok.parity;
                    out_south        <= 1'b0;
                end
                default:
                begin
                end
            endcase
        end
        // second half of a split heads south
        if (state == EMIT_SPLIT && x_out_ready)
        begin
            out_tok   <= split_tok;
            out_south <= 1'b1;
        end
    end

    // per parity occupancy of the FIFO
    assign push_par = push ? (push_data.parity ? 2'b10 : 2'b01) : 2'b00;
    assign pop_par  = pop ? (pop_data.parity ? 2'b10 : 2'b01) : 2'b00;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            par_cnt[0] <= '0;
            par_cnt[1] <= '0;
        end
        else
        begin
            for (int p = 0; p < 2; p++)
            begin
                if (push_par[p] && !pop_par[p])
                begin
                    par_cnt[p] <= par_cnt[p] + 1'b1;
                end
                else if (pop_par[p] && !push_par[p])
                begin
                    par_cnt[p] <= par_cnt[p] - 1'b1;
                end
            end
        end
    end

    assign x_out_data  = out_tok;
    assign y_out_data  = out_tok;
    assign x_out_valid = (state == EMIT && !out_south) || (state == EMIT_SPLIT);
    assign y_out_valid = (state == EMIT) && out_south;
    assign fetch_valid = (state == FETCH);
    assign fetch_pc    = cur_tok.pc;
    assign accept      = (state == EXEC) && (opcode == ACCEPT) && (cur_tok.parity == cur_parity);

    assign item_live = (state == FETCH) || (state == EXEC) ||
                       ((state == EMIT || state == EMIT_SPLIT) && out_tok.parity == cur_parity);
    assign running   = item_live || (par_cnt[cur_parity] != '0);

endmodule

`default_nettype wire

/* design/fetch_arbiter_rr.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_arbiter_rr #(
    parameter int N = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [N-1:0]           req_valid,
    input  regex_mesh_pkg::pc_t    req_pc [N],
    output logic [N-1:0]           req_ready,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output regex_mesh_pkg::pc_t    wb_adr,
    input  logic                   wb_ack,
    input  regex_mesh_pkg::instr_t wb_dat_i,
    output regex_mesh_pkg::instr_t rsp_data
);
    localparam int IW = (N > 1) ? $clog2(N) : 1;

    logic          busy;
    logic [IW-1:0] grant;
    logic [IW-1:0] ptr;
    logic [IW-1:0] pick;
    logic          found;

    // first requester at or after the rotating pointer
    always_comb
    begin
        int idx;
        found = 1'b0;
        pick  = ptr;
        for (int i = 0; i < N; i++)
        begin
            idx = (int'(ptr) + i) % N;
            if (!found && req_valid[idx])
            begin
                found = 1'b1;
                pick  = IW'(idx);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy  <= 1'b0;
            grant <= '0;
            ptr   <= '0;
        end
        else if (!busy)
        begin
            if (found)
            begin
                busy  <= 1'b1;
                grant <= pick;
            end
        end
        else if (wb_ack)
        begin
            busy <= 1'b0;
            // next search starts past the last winner
            ptr  <= (grant == IW'(N - 1)) ? '0 : grant + 1'b1;
        end
    end

    // grant stays locked from stb to ack
    assign wb_cyc   = busy;
    assign wb_stb   = busy;
    assign wb_adr   = req_pc[grant];
    assign rsp_data = wb_dat_i;

    always_comb
    begin
        req_ready        = '0;
        req_ready[grant] = busy && wb_ack;
    end

endmodule

`default_nettype wire

/* design/pc_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module pc_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      push,
    input  regex_mesh_pkg::pc_token_t push_data,
    input  logic                      pop,
    output regex_mesh_pkg::pc_token_t pop_data,
    output logic                      empty,
    output logic                      full
);
    import regex_mesh_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    pc_token_t     mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    function automatic logic [AW-1:0] bump(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty    = (count == '0);
    assign full     = (count == CW'(DEPTH));
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= bump(wr_ptr);
            end
            if (do_pop)
            begin
                rd_ptr <= bump(rd_ptr);
            end
            if (do_push && !do_pop)
            begin
                count <= count + 1'b1;
            end
            else if (do_pop && !do_push)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/pc_insert_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module pc_insert_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  regex_mesh_pkg::pc_token_t in0_data,
    input  logic                      in0_valid,
    output logic                      in0_ready,
    input  regex_mesh_pkg::pc_token_t in1_data,
    input  logic                      in1_valid,
    output logic                      in1_ready,
    output regex_mesh_pkg::pc_token_t out_data,
    output logic                      out_valid,
    input  logic                      out_ready
);
    logic locked;
    logic lock_sel;
    logic sel;

    // in0 wins unless a stalled grant is still pending
    assign sel       = locked ? lock_sel : !in0_valid;
    assign out_valid = sel ? in1_valid : in0_valid;
    assign out_data  = sel ? in1_data : in0_data;
    assign in0_ready = out_ready && !sel;
    assign in1_ready = out_ready && sel;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            locked   <= 1'b0;
            lock_sel <= 1'b0;
        end
        else if (out_valid && !out_ready)
        begin
            locked   <= 1'b1;
            lock_sel <= sel;
        end
        else
        begin
            locked <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/regex_mesh_pkg.sv */
`default_nettype none

package regex_mesh_pkg;

    // input character
    typedef logic [7:0] char_t;

    // instruction address
    typedef logic [7:0] pc_t;

    // instruction word: opcode in [15:14], char or target in [7:0]
    typedef logic [15:0] instr_t;

    typedef enum logic [1:0] {
        MATCH  = 2'd0,
        JMP    = 2'd1,
        SPLIT  = 2'd2,
        ACCEPT = 2'd3
    } opcode_e;

    // token carried on every ring channel
    typedef struct packed {
        pc_t  pc;
        logic parity;
    } pc_token_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        EXEC,
        EMIT,
        EMIT_SPLIT
    } engine_state_e;

    function automatic opcode_e instr_opcode(input instr_t instr);
        return opcode_e'(instr[15:14]);
    endfunction

    // character for MATCH, target for JMP and SPLIT
    function automatic pc_t instr_operand(input instr_t instr);
        return instr[7:0];
    endfunction

endpackage

`default_nettype wire

/* design/regex_mesh_top.sv */
`timescale 1ns/1ns
`default_nettype none

module regex_mesh_top #(
    parameter int BB_N_X     = 2,
    parameter int BB_N_Y     = 2,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  regex_mesh_pkg::char_t     cur_char,
    input  logic                      cur_parity,
    input  logic                      enable,
    input  regex_mesh_pkg::pc_token_t override_data,
    input  logic                      override_valid,
    output logic                      override_ready,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output regex_mesh_pkg::pc_t       wb_adr,
    input  logic                      wb_ack,
    input  regex_mesh_pkg::instr_t    wb_dat_i,
    output logic                      any_bb_accept,
    output logic                      any_bb_running,
    output logic                      all_bb_full
);
    import regex_mesh_pkg::*;

    localparam int NB = BB_N_X * BB_N_Y;

    // x channel [row][col] feeds engine col, col BB_N_X is the row's east end
    pc_token_t x_data  [BB_N_Y][BB_N_X+1];
    logic      x_valid [BB_N_Y][BB_N_X+1];
    logic      x_ready [BB_N_Y][BB_N_X+1];
    pc_token_t y_data  [BB_N_Y+1][BB_N_X];
    logic      y_valid [BB_N_Y+1][BB_N_X];
    logic      y_ready [BB_N_Y+1][BB_N_X];

    logic [NB-1:0] fetch_valid;
    logic [NB-1:0] fetch_ready;
    pc_t           fetch_pc [NB];
    instr_t        fetch_data;
    logic [NB-1:0] bb_accept;
    logic [NB-1:0] bb_running;
    logic [NB-1:0] bb_full;

    for (genvar gy = 0; gy < BB_N_Y; gy++)
    begin : g_row
        for (genvar gx = 0; gx < BB_N_X; gx++)
        begin : g_col
            engine_node #(
                .FIFO_DEPTH (FIFO_DEPTH)
            ) engine_i (
                .clk         (clk),
                .rst_n       (rst_n),
                .cur_char    (cur_char),
                .cur_parity  (cur_parity),
                .enable      (enable),
                .x_in_data   (x_data[gy][gx]),
                .x_in_valid  (x_valid[gy][gx]),
                .x_in_ready  (x_ready[gy][gx]),
                .y_in_data   (y_data[gy][gx]),
                .y_in_valid  (y_valid[gy][gx]),
                .y_in_ready  (y_ready[gy][gx]),
                .x_out_data  (x_data[gy][gx+1]),
                .x_out_valid (x_valid[gy][gx+1]),
                .x_out_ready (x_ready[gy][gx+1]),
                .y_out_data  (y_data[gy+1][gx]),
                .y_out_valid (y_valid[gy+1][gx]),
                .y_out_ready (y_ready[gy+1][gx]),
                .fetch_valid (fetch_valid[gy*BB_N_X+gx]),
                .fetch_pc    (fetch_pc[gy*BB_N_X+gx]),
                .fetch_ready (fetch_ready[gy*BB_N_X+gx]),
                .fetch_data  (fetch_data),
                .accept      (bb_accept[gy*BB_N_X+gx]),
                .running     (bb_running[gy*BB_N_X+gx]),
                .full        (bb_full[gy*BB_N_X+gx])
            );
        end
    end

    // row 0 wrap shares its west input with start PC insertion
    pc_insert_arbiter insert_arb_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in0_data  (override_data),
        .in0_valid (override_valid),
        .in0_ready (override_ready),
        .in1_data  (x_data[0][BB_N_X]),
        .in1_valid (x_valid[0][BB_N_X]),
        .in1_ready (x_ready[0][BB_N_X]),
        .out_data  (x_data[0][0]),
        .out_valid (x_valid[0][0]),
        .out_ready (x_ready[0][0])
    );

    for (genvar gy = 1; gy < BB_N_Y; gy++)
    begin : g_xwrap
        assign x_data[gy][0]       = x_data[gy][BB_N_X];
        assign x_valid[gy][0]      = x_valid[gy][BB_N_X];
        assign x_ready[gy][BB_N_X] = x_ready[gy][0];
    end

    for (genvar gx = 0; gx < BB_N_X; gx++)
    begin : g_ywrap
        assign y_data[0][gx]       = y_data[BB_N_Y][gx];
        assign y_valid[0][gx]      = y_valid[BB_N_Y][gx];
        assign y_ready[BB_N_Y][gx] = y_ready[0][gx];
    end

    // response is broadcast, the engine seeing ready owns it
    fetch_arbiter_rr #(
        .N (NB)
    ) fetch_arb_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (fetch_valid),
        .req_pc    (fetch_pc),
        .req_ready (fetch_ready),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_adr    (wb_adr),
        .wb_ack    (wb_ack),
        .wb_dat_i  (wb_dat_i),
        .rsp_data  (fetch_data)
    );

    assign any_bb_accept  = |bb_accept;
    assign any_bb_running = |bb_running;
    assign all_bb_full    = &bb_full;

endmodule

`default_nettype wire

/* regex_mesh.f */
design/regex_mesh_pkg.sv
design/pc_fifo.sv
design/pc_insert_arbiter.sv
design/fetch_arbiter_rr.sv
design/engine_node.sv
design/regex_mesh_top.sv
sim/tb_clock_gen.sv
sim/regex_mesh_checker.sv
sim/regex_mesh_tb.sv

/* sim/regex_mesh_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module regex_mesh_checker (
    input  logic clk,
    input  logic rst_n,
    input  logic any_bb_accept,
    input  logic any_bb_running,
    input  logic all_bb_full,
    input  logic override_ready,
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic idle_check,
    input  logic string_start,
    input  logic string_end,
    input  logic expected_match,
    input  int   string_idx,
    output int   error_count,
    output int   check_count
);
    logic seen;

    always @(posedge clk)
    begin : compare_proc
        int new_errs;
        int new_checks;
        new_errs   = 0;
        new_checks = 0;
        if (!rst_n)
        begin
            seen        <= 1'b0;
            error_count <= 0;
            check_count <= 0;
        end
        else
        begin
            // accept latch for the string in progress
            if (string_start)
            begin
                seen <= 1'b0;
            end
            else if (any_bb_accept)
            begin
                seen <= 1'b1;
            end
            if (idle_check)
            begin
                new_checks++;
                if (any_bb_accept || any_bb_running || all_bb_full || wb_cyc || wb_stb)
                begin
                    $display("** Error at %0t ns: outputs not idle after reset", $time);
                    $display("   accept %0b running %0b full %0b cyc %0b stb %0b",
                             any_bb_accept, any_bb_running, all_bb_full, wb_cyc, wb_stb);
                    new_errs++;
                end
            end
            // override has to stall while every FIFO is full
            if (all_bb_full && override_ready)
            begin
                $display("** Error at %0t ns: override ready while all FIFOs are full",
                         $time);
                new_errs++;
            end
            if (string_end)
            begin
                new_checks++;
                if ((seen || any_bb_accept) != expected_match)
                begin
                    $display("** Error at %0t ns: string %0d expected match %0b, got %0b",
                             $time, string_idx, expected_match, seen || any_bb_accept);
                    new_errs++;
                end
            end
            error_count <= error_count + new_errs;
            check_count <= check_count + new_checks;
        end
    end

endmodule

`default_nettype wire

/* sim/regex_mesh_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module regex_mesh_tb;
    import regex_mesh_pkg::*;

    logic        clk;
    logic        rst_n;
    char_t       cur_char;
    logic        cur_parity;
    logic        enable;
    pc_token_t   override_data;
    logic        override_valid;
    logic        override_ready;
    logic        wb_cyc;
    logic        wb_stb;
    pc_t         wb_adr;
    logic        wb_ack = 1'b0;
    instr_t      wb_dat_i = '0;
    logic        any_bb_accept;
    logic        any_bb_running;
    logic        all_bb_full;
    logic        idle_check;
    logic        string_start;
    logic        string_end;
    logic        expected_match;
    int          string_idx;
    int          error_count;
    int          check_count;
    int          ins_count = 0;
    int          cycle_count = 0;
    int          cycle_limit;
    int          ack_wait = 0;
    // words 0..255 are instruction memory, test records start at 256
    logic [15:0] testdata [512];

    tb_clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (5)
    ) clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    regex_mesh_top #(
        .BB_N_X     (2),
        .BB_N_Y     (2),
        .FIFO_DEPTH (4)
    ) UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .cur_char       (cur_char),
        .cur_parity     (cur_parity),
        .enable         (enable),
        .override_data  (override_data),
        .override_valid (override_valid),
        .override_ready (override_ready),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_adr         (wb_adr),
        .wb_ack         (wb_ack),
        .wb_dat_i       (wb_dat_i),
        .any_bb_accept  (any_bb_accept),
        .any_bb_running (any_bb_running),
        .all_bb_full    (all_bb_full)
    );

    regex_mesh_checker checker_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .any_bb_accept  (any_bb_accept),
        .any_bb_running (any_bb_running),
        .all_bb_full    (all_bb_full),
        .override_ready (override_ready),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .idle_check     (idle_check),
        .string_start   (string_start),
        .string_end     (string_end),
        .expected_match (expected_match),
        .string_idx     (string_idx),
        .error_count    (error_count),
        .check_count    (check_count)
    );

    // instruction memory, one wait state before ack
    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            wb_ack   <= 1'b0;
            ack_wait <= 0;
        end
        else if (wb_cyc && wb_stb && !wb_ack)
        begin
            if (ack_wait == 1)
            begin
                wb_ack   <= 1'b1;
                wb_dat_i <= testdata[{1'b0, wb_adr}];
                ack_wait <= 0;
            end
            else
            begin
                ack_wait <= ack_wait + 1;
            end
        end
        else
        begin
            wb_ack   <= 1'b0;
            ack_wait <= 0;
        end
    end

    // count start PCs taken by the override channel
    always @(posedge clk)
    begin
        if (override_valid && override_ready)
        begin
            ins_count <= ins_count + 1;
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    // one character step: insert start PCs, then let the current parity drain
    task automatic feed_char(input char_t ch, input pc_t start_pc, input int copies);
        int target;
        cur_char = ch;
        if (copies > 0)
        begin
            target               = ins_count + copies;
            override_data.pc     = start_pc;
            override_data.parity = cur_parity;
            override_valid       = 1'b1;
            do
                @(negedge clk);
            while (ins_count != target);
            override_valid = 1'b0;
        end
        do
            @(negedge clk);
        while (any_bb_running);
        cur_parity = !cur_parity;
    endtask

    initial
    begin
        int   rec;
        int   len;
        int   copies;
        int   total_chars;
        int   strings;
        pc_t  start_pc;
        cur_char       = '0;
        cur_parity     = 1'b0;
        enable         = 1'b0;
        override_data  = '0;
        override_valid = 1'b0;
        idle_check     = 1'b0;
        string_start   = 1'b0;
        string_end     = 1'b0;
        expected_match = 1'b0;
        string_idx     = 0;
        cycle_limit    = 1000000;
        for (int i = 0; i < 512; i++)
        begin
            testdata[i] = 16'(i);
        end
        $readmemh("sim/regex_mesh_testdata.txt", testdata);

        // the flush step counts as one more character per string
        rec         = 256;
        total_chars = 0;
        strings     = 0;
        while (rec < 500 && testdata[rec] != 16'hffff)
        begin
            total_chars += int'(testdata[rec][7:0]);
            strings++;
            rec += 2 + int'(testdata[rec][7:0]);
        end
        cycle_limit = 400 * (total_chars + strings) + 100;

        wait (rst_n === 1'b1);
        @(negedge clk);
        idle_check = 1'b1;
        @(negedge clk);
        idle_check = 1'b0;
        enable     = 1'b1;

        rec = 256;
        while (rec < 500 && testdata[rec] != 16'hffff)
        begin
            start_pc       = testdata[rec][15:8];
            len            = int'(testdata[rec][7:0]);
            copies         = int'(testdata[rec + 1][15:8]);
            expected_match = testdata[rec + 1][0];
            string_start   = 1'b1;
            @(negedge clk);
            string_start = 1'b0;
            for (int c = 0; c < len; c++)
            begin
                feed_char(testdata[rec + 2 + c][7:0], start_pc, copies);
            end
            // no start PC here, tokens left after the last char reach ACCEPT
            feed_char(8'h00, start_pc, 0);
            string_end = 1'b1;
            @(negedge clk);
            string_end = 1'b0;
            string_idx++;
            rec += 2 + len;
        end

        @(negedge clk);
        if (strings == 0 || check_count != strings + 1)
        begin
            $display("not every expected check ran: %0d of %0d", check_count, strings + 1);
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && strings > 0 && check_count == strings + 1)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/regex_mesh_testdata.txt */
// instruction words from address 000, test records from address 100 (hex)
// record: {start pc, length} {copies per char, expected} then one char per word, ffff ends
@000
0061 0062 c000
@010
0061 8014 0062 4015 0063 c000
@020
0061 8024 0062 4021 0063 c000
@100
// literal ab
0004 0101 78 61 62 79
0004 0101 61 62 61 62
0002 0100 62 61
0003 0101 61 61 62
0001 0100 61
// alternation a(b|c)
1002 0101 61 63
1002 0101 61 62
1002 0100 61 64
// loop ab*c
2005 0101 61 62 62 62 63
2004 0100 61 62 62 64
2002 0101 61 63
// several start PCs per char on a held override
2004 0201 61 62 62 63
0003 0301 78 61 62
ffff

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release on a falling edge, clear of the sampling edge
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire
